// File: design/ooo_config.svh
`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// reorder buffer entries, keep a power of two
`define OOO_ROB_DEPTH 8

// log2 of the rob depth, width of a rename tag
`define OOO_TAG_W 3

// architectural integer registers
`define OOO_NUM_REGS 32

`endif

// File: design/ooo_pkg.sv
`include "ooo_config.svh"

package ooo_pkg;

    // alu operations
    // immediate forms share these, use_imm picks the operand
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        LUI
    } op_t;

    // fetch side of the instruction register
    typedef enum logic [1:0] {
        IDLE,
        WAIT_RESP,
        HOLD
    } fetch_state_t;

    // rob index, doubles as the rename tag
    typedef logic [`OOO_TAG_W-1:0] tag_t;

endpackage : ooo_pkg

// File: design/alu.sv
`timescale 1ns/1ps

module alu (
    input  ooo_pkg::op_t op_i,
    input  logic [31:0]  a_i,
    input  logic [31:0]  b_i,
    output logic [31:0]  y_o
);

    always_comb begin
        case (op_i)
            ooo_pkg::ADD:  y_o = a_i + b_i;
            ooo_pkg::SUB:  y_o = a_i - b_i;
            ooo_pkg::AND:  y_o = a_i & b_i;
            ooo_pkg::OR:   y_o = a_i | b_i;
            ooo_pkg::XOR:  y_o = a_i ^ b_i;
            // shift amount from the low five bits only
            ooo_pkg::SLL:  y_o = a_i << b_i[4:0];
            ooo_pkg::SRL:  y_o = a_i >> b_i[4:0];
            ooo_pkg::SRA:  y_o = $signed(a_i) >>> b_i[4:0];
            ooo_pkg::SLT:  y_o = {31'd0, $signed(a_i) < $signed(b_i)};
            ooo_pkg::SLTU: y_o = {31'd0, a_i < b_i};
            // upper immediate arrives already shifted
            ooo_pkg::LUI:  y_o = b_i;
            default:       y_o = 32'd0;
        endcase
    end

endmodule : alu

// File: design/ir.sv
`timescale 1ns/1ps

module ir (
    input  logic               clk,
    input  logic               reset_i,
    input  logic               instr_mem_resp_i,
    input  logic [31:0]        instr_mem_rdata_i,
    input  logic               dispatch_ready_i,
    output logic               instr_read_o,
    output logic [31:0]        instr_mem_address_o,
    output logic               dispatch_o,
    output ooo_pkg::op_t       op_o,
    output logic [4:0]         rd_o,
    output logic [4:0]         rs1_o,
    output logic [4:0]         rs2_o,
    output logic [31:0]        imm_o,
    output logic               use_imm_o
);

    ooo_pkg::fetch_state_t state_q;
    logic [31:0] pc_q;
    logic [31:0] instr_q;
    logic [2:0]  funct3;
    logic        is_lui;
    logic        is_reg;

    // fetch fsm, one word in flight at a time
    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ooo_pkg::IDLE;
            pc_q    <= '0;
        end else begin
            case (state_q)
                ooo_pkg::IDLE: begin
                    state_q <= ooo_pkg::WAIT_RESP;
                end
                ooo_pkg::WAIT_RESP: begin
                    if (instr_mem_resp_i) begin
                        state_q <= ooo_pkg::HOLD;
                    end
                end
                ooo_pkg::HOLD: begin
                    // next fetch only once the held word leaves
                    if (dispatch_ready_i) begin
                        state_q <= ooo_pkg::WAIT_RESP;
                        pc_q    <= pc_q + 32'd4;
                    end
                end
                default: begin
                    state_q <= ooo_pkg::IDLE;
                end
            endcase
        end
    end

    // held instruction word
    always_ff @(posedge clk) begin
        if (state_q == ooo_pkg::WAIT_RESP && instr_mem_resp_i) begin
            instr_q <= instr_mem_rdata_i;
        end
    end

    assign instr_read_o        = (state_q == ooo_pkg::WAIT_RESP);
    assign instr_mem_address_o = pc_q;
    assign dispatch_o          = (state_q == ooo_pkg::HOLD) && dispatch_ready_i;

    // decode, only OP, OP-IMM and LUI exist
    assign funct3 = instr_q[14:12];
    assign is_lui = (instr_q[6:0] == 7'b0110111);
    assign is_reg = (instr_q[6:0] == 7'b0110011);

    always_comb begin
        case (funct3)
            // bit 30 selects sub only for the register form
            3'b000:  op_o = (is_reg && instr_q[30]) ? ooo_pkg::SUB : ooo_pkg::ADD;
            3'b001:  op_o = ooo_pkg::SLL;
            3'b010:  op_o = ooo_pkg::SLT;
            3'b011:  op_o = ooo_pkg::SLTU;
            3'b100:  op_o = ooo_pkg::XOR;
            // srl/sra and srli/srai both use bit 30
            3'b101:  op_o = instr_q[30] ? ooo_pkg::SRA : ooo_pkg::SRL;
            3'b110:  op_o = ooo_pkg::OR;
            default: op_o = ooo_pkg::AND;
        endcase
        if (is_lui) begin
            op_o = ooo_pkg::LUI;
        end
    end

    assign rd_o      = instr_q[11:7];
    // lui has no rs1, upper bits are immediate
    assign rs1_o     = is_lui ? 5'd0 : instr_q[19:15];
    assign rs2_o     = instr_q[24:20];
    assign use_imm_o = !is_reg;
    assign imm_o     = is_lui ? {instr_q[31:12], 12'b0} : {{20{instr_q[31]}}, instr_q[31:20]};

    // request and address hold until the memory answers
    assert property (@(posedge clk) disable iff (reset_i)
        state_q == ooo_pkg::WAIT_RESP && !instr_mem_resp_i
        |=> instr_read_o && $stable(instr_mem_address_o));

endmodule : ir

// File: design/rob.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module rob (
    input  logic          clk,
    input  logic          reset_i,
    input  logic          alloc_i,
    input  logic [4:0]    alloc_rd_i,
    input  ooo_pkg::op_t  alloc_op_i,
    output ooo_pkg::tag_t alloc_tag_o,
    output logic          full_o,
    input  logic          cdb0_valid_i,
    input  ooo_pkg::tag_t cdb0_tag_i,
    input  logic [31:0]   cdb0_data_i,
    input  logic          cdb1_valid_i,
    input  ooo_pkg::tag_t cdb1_tag_i,
    input  logic [31:0]   cdb1_data_i,
    input  ooo_pkg::tag_t rd_tag_a_i,
    input  ooo_pkg::tag_t rd_tag_b_i,
    output logic          done_a_o,
    output logic [31:0]   data_a_o,
    output logic          done_b_o,
    output logic [31:0]   data_b_o,
    output logic          commit_valid_o,
    output ooo_pkg::tag_t commit_tag_o,
    output logic [4:0]    commit_rd_o,
    output logic [31:0]   commit_data_o
);

    logic [`OOO_ROB_DEPTH-1:0] valid_q;
    logic [`OOO_ROB_DEPTH-1:0] done_q;
    logic [4:0]                rd_q   [`OOO_ROB_DEPTH];
    logic [31:0]               data_q [`OOO_ROB_DEPTH];
    ooo_pkg::tag_t             head_q;
    ooo_pkg::tag_t             tail_q;
    logic [`OOO_TAG_W:0]       count_q;

    assign alloc_tag_o = tail_q;
    // depth is a power of two, so the top count bit means full
    assign full_o      = count_q[`OOO_TAG_W];

    // pointers and per-entry status
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_i) begin
                valid_q[tail_q] <= 1'b1;
                done_q[tail_q]  <= 1'b0;
                tail_q          <= tail_q + 1'b1;
            end
            // completion from either cdb lane
            if (cdb0_valid_i) begin
                done_q[cdb0_tag_i] <= 1'b1;
            end
            if (cdb1_valid_i) begin
                done_q[cdb1_tag_i] <= 1'b1;
            end
            if (commit_valid_o) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
            count_q <= count_q + alloc_i - commit_valid_o;
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (alloc_i) begin
            rd_q[tail_q] <= alloc_rd_i;
        end
        if (cdb0_valid_i) begin
            data_q[cdb0_tag_i] <= cdb0_data_i;
        end
        if (cdb1_valid_i) begin
            data_q[cdb1_tag_i] <= cdb1_data_i;
        end
    end

    // finished but uncommitted values for dispatch
    assign done_a_o = valid_q[rd_tag_a_i] && done_q[rd_tag_a_i];
    assign data_a_o = data_q[rd_tag_a_i];
    assign done_b_o = valid_q[rd_tag_b_i] && done_q[rd_tag_b_i];
    assign data_b_o = data_q[rd_tag_b_i];

    // in-order retirement of one entry per cycle
    assign commit_valid_o = valid_q[head_q] && done_q[head_q];
    assign commit_tag_o   = head_q;
    assign commit_rd_o    = rd_q[head_q];
    assign commit_data_o  = data_q[head_q];

    // stations only broadcast tags still in flight
    assert property (@(posedge clk) disable iff (reset_i)
        cdb0_valid_i |-> valid_q[cdb0_tag_i] && !done_q[cdb0_tag_i]);
    assert property (@(posedge clk) disable iff (reset_i)
        cdb1_valid_i |-> valid_q[cdb1_tag_i] && !done_q[cdb1_tag_i]);

endmodule : rob

// File: design/regfile.sv
`timescale 1ns/1ps
`include "ooo_config.svh"

module regfile (
    input  logic          clk,
    input  logic          reset_i,
    input  logic [4:0]    rs1_i,
    input  logic [4:0]    rs2_i,
    input  logic          rename_i,
    input  logic [4:0]    rename_rd_i,
    input  ooo_pkg::tag_t rename_tag_i,
    input  logic          commit_i,
    input  logic [4:0]    commit_rd_i,
    input  ooo_pkg::tag_t commit_tag_i,
    input  logic [31:0]   commit_data_i,
    output logic [31:0]   val1_o,
    output logic          busy1_o,
    output ooo_pkg::tag_t tag1_o,
    output logic [31:0]   val2_o,
    output logic          busy2_o,
    output ooo_pkg::tag_t tag2_o
);

    logic [31:0]              val_q [`OOO_NUM_REGS];
    ooo_pkg::tag_t            tag_q [`OOO_NUM_REGS];
    logic [`OOO_NUM_REGS-1:0] busy_q;

    // architectural values and busy flags
    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= '0;
            for (int i = 0; i < `OOO_NUM_REGS; i++) begin
                val_q[i] <= '0;
            end
        end else begin
            // x0 shows up on the trace but is never stored
            if (commit_i && commit_rd_i != 5'd0) begin
                val_q[commit_rd_i] <= commit_data_i;
                // only the youngest producer frees the register
                if (tag_q[commit_rd_i] == commit_tag_i) begin
                    busy_q[commit_rd_i] <= 1'b0;
                end
            end
            // later assignment, so a same-cycle rename wins
            if (rename_i && rename_rd_i != 5'd0) begin
                busy_q[rename_rd_i] <= 1'b1;
            end
        end
    end

    // rename tags
    always_ff @(posedge clk) begin
        if (rename_i && rename_rd_i != 5'd0) begin
            tag_q[rename_rd_i] <= rename_tag_i;
        end
    end

    assign val1_o  = (rs1_i == 5'd0) ? 32'd0 : val_q[rs1_i];
    assign busy1_o = busy_q[rs1_i];
    assign tag1_o  = tag_q[rs1_i];
    assign val2_o  = (rs2_i == 5'd0) ? 32'd0 : val_q[rs2_i];
    assign busy2_o = busy_q[rs2_i];
    assign tag2_o  = tag_q[rs2_i];

endmodule : regfile

// File: design/reservation_station.sv
`timescale 1ns/1ps

module reservation_station (
    input  logic          clk,
    input  logic          reset_i,
    input  logic          load_i,
    input  ooo_pkg::op_t  op_i,
    input  logic          src1_valid_i,
    input  ooo_pkg::tag_t src1_tag_i,
    input  logic [31:0]   src1_data_i,
    input  logic          src2_valid_i,
    input  ooo_pkg::tag_t src2_tag_i,
    input  logic [31:0]   src2_data_i,
    input  ooo_pkg::tag_t dest_tag_i,
    input  logic          cdb0_valid_i,
    input  ooo_pkg::tag_t cdb0_tag_i,
    input  logic [31:0]   cdb0_data_i,
    input  logic          cdb1_valid_i,
    input  ooo_pkg::tag_t cdb1_tag_i,
    input  logic [31:0]   cdb1_data_i,
    output logic          empty_o,
    output logic          fire_o,
    output ooo_pkg::tag_t fire_tag_o,
    output logic [31:0]   result_o
);

    logic          busy_q;
    logic          v1_q;
    logic          v2_q;
    ooo_pkg::op_t  op_q;
    ooo_pkg::tag_t t1_q;
    ooo_pkg::tag_t t2_q;
    ooo_pkg::tag_t dest_q;
    logic [31:0]   d1_q;
    logic [31:0]   d2_q;
    logic          hit1_0;
    logic          hit1_1;
    logic          hit2_0;
    logic          hit2_1;

    // snoop both lanes for missing operands
    assign hit1_0 = busy_q && !v1_q && cdb0_valid_i && (cdb0_tag_i == t1_q);
    assign hit1_1 = busy_q && !v1_q && cdb1_valid_i && (cdb1_tag_i == t1_q);
    assign hit2_0 = busy_q && !v2_q && cdb0_valid_i && (cdb0_tag_i == t2_q);
    assign hit2_1 = busy_q && !v2_q && cdb1_valid_i && (cdb1_tag_i == t2_q);

    // occupancy and operand ready bits
    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy_q <= 1'b0;
            v1_q   <= 1'b0;
            v2_q   <= 1'b0;
        end else if (load_i) begin
            busy_q <= 1'b1;
            v1_q   <= src1_valid_i;
            v2_q   <= src2_valid_i;
        end else begin
            // firing frees the entry
            if (fire_o) begin
                busy_q <= 1'b0;
            end
            if (hit1_0 || hit1_1) begin
                v1_q <= 1'b1;
            end
            if (hit2_0 || hit2_1) begin
                v2_q <= 1'b1;
            end
        end
    end

    // operands, tags and destination
    always_ff @(posedge clk) begin
        if (load_i) begin
            op_q   <= op_i;
            t1_q   <= src1_tag_i;
            d1_q   <= src1_data_i;
            t2_q   <= src2_tag_i;
            d2_q   <= src2_data_i;
            dest_q <= dest_tag_i;
        end else begin
            if (hit1_0) begin
                d1_q <= cdb0_data_i;
            end else if (hit1_1) begin
                d1_q <= cdb1_data_i;
            end
            if (hit2_0) begin
                d2_q <= cdb0_data_i;
            end else if (hit2_1) begin
                d2_q <= cdb1_data_i;
            end
        end
    end

    assign empty_o    = !busy_q;
    assign fire_o     = busy_q && v1_q && v2_q;
    assign fire_tag_o = dest_q;

    alu alu (
        .op_i(op_q),
        .a_i (d1_q),
        .b_i (d2_q),
        .y_o (result_o)
    );

endmodule : reservation_station

// File: design/ooo.sv
`timescale 1ns/1ps

module ooo (
    input  logic        clk,
    input  logic        reset_i,
    input  logic        instr_mem_resp_i,
    input  logic [31:0] instr_mem_rdata_i,
    output logic        instr_read_o,
    output logic [31:0] instr_mem_address_o,
    output logic        commit_valid_o,
    output logic [4:0]  commit_rd_o,
    output logic [31:0] commit_data_o
);

    // decoded instruction from ir
    logic          dispatch;
    logic          dispatch_ready;
    ooo_pkg::op_t  dec_op;
    logic [4:0]    dec_rd, dec_rs1, dec_rs2;
    logic [31:0]   dec_imm;
    logic          dec_use_imm;
    // rob side
    ooo_pkg::tag_t alloc_tag, commit_tag;
    logic          rob_full;
    logic          done_a, done_b;
    logic [31:0]   rob_data_a, rob_data_b;
    // register file reads
    logic [31:0]   reg_val1, reg_val2;
    logic          busy1, busy2;
    ooo_pkg::tag_t tag1, tag2;
    // resolved operands, valid bit on top
    logic [32:0]   opnd1, opnd2_reg, opnd2;
    // station outputs, which are also the two cdb lanes
    logic          rs0_empty, rs1_empty;
    logic          rs0_fire, rs1_fire;
    ooo_pkg::tag_t rs0_tag, rs1_tag;
    logic [31:0]   rs0_result, rs1_result;

    // pick an operand source at dispatch
    // order is free register, cdb bypass, finished rob entry, else wait
    function automatic logic [32:0] resolve(
        input logic          busy,
        input ooo_pkg::tag_t tag,
        input logic [31:0]   reg_val,
        input logic          rob_done,
        input logic [31:0]   rob_data,
        input logic          c0_valid,
        input ooo_pkg::tag_t c0_tag,
        input logic [31:0]   c0_data,
        input logic          c1_valid,
        input ooo_pkg::tag_t c1_tag,
        input logic [31:0]   c1_data
    );
        if (!busy) begin
            return {1'b1, reg_val};
        end
        if (c0_valid && c0_tag == tag) begin
            return {1'b1, c0_data};
        end
        if (c1_valid && c1_tag == tag) begin
            return {1'b1, c1_data};
        end
        if (rob_done) begin
            return {1'b1, rob_data};
        end
        // station picks it up from the cdb later
        return {1'b0, 32'd0};
    endfunction

    assign dispatch_ready = !rob_full && (rs0_empty || rs1_empty);

    assign opnd1 = resolve(busy1, tag1, reg_val1, done_a, rob_data_a,
                           rs0_fire, rs0_tag, rs0_result, rs1_fire, rs1_tag, rs1_result);
    assign opnd2_reg = resolve(busy2, tag2, reg_val2, done_b, rob_data_b,
                               rs0_fire, rs0_tag, rs0_result, rs1_fire, rs1_tag, rs1_result);
    // immediate forms never wait on rs2
    assign opnd2 = dec_use_imm ? {1'b1, dec_imm} : opnd2_reg;

    ir ir (
        .clk                (clk),
        .reset_i            (reset_i),
        .instr_mem_resp_i   (instr_mem_resp_i),
        .instr_mem_rdata_i  (instr_mem_rdata_i),
        .dispatch_ready_i   (dispatch_ready),
        .instr_read_o       (instr_read_o),
        .instr_mem_address_o(instr_mem_address_o),
        .dispatch_o         (dispatch),
        .op_o               (dec_op),
        .rd_o               (dec_rd),
        .rs1_o              (dec_rs1),
        .rs2_o              (dec_rs2),
        .imm_o              (dec_imm),
        .use_imm_o          (dec_use_imm)
    );

    rob rob (
        .clk           (clk),
        .reset_i       (reset_i),
        .alloc_i       (dispatch),
        .alloc_rd_i    (dec_rd),
        .alloc_op_i    (dec_op),
        .alloc_tag_o   (alloc_tag),
        .full_o        (rob_full),
        .cdb0_valid_i  (rs0_fire),
        .cdb0_tag_i    (rs0_tag),
        .cdb0_data_i   (rs0_result),
        .cdb1_valid_i  (rs1_fire),
        .cdb1_tag_i    (rs1_tag),
        .cdb1_data_i   (rs1_result),
        .rd_tag_a_i    (tag1),
        .rd_tag_b_i    (tag2),
        .done_a_o      (done_a),
        .data_a_o      (rob_data_a),
        .done_b_o      (done_b),
        .data_b_o      (rob_data_b),
        .commit_valid_o(commit_valid_o),
        .commit_tag_o  (commit_tag),
        .commit_rd_o   (commit_rd_o),
        .commit_data_o (commit_data_o)
    );

    regfile regfile (
        .clk          (clk),
        .reset_i      (reset_i),
        .rs1_i        (dec_rs1),
        .rs2_i        (dec_rs2),
        .rename_i     (dispatch),
        .rename_rd_i  (dec_rd),
        .rename_tag_i (alloc_tag),
        .commit_i     (commit_valid_o),
        .commit_rd_i  (commit_rd_o),
        .commit_tag_i (commit_tag),
        .commit_data_i(commit_data_o),
        .val1_o       (reg_val1),
        .busy1_o      (busy1),
        .tag1_o       (tag1),
        .val2_o       (reg_val2),
        .busy2_o      (busy2),
        .tag2_o       (tag2)
    );

    // station 0 takes priority when both are free
    reservation_station rs0 (
        .clk(clk), .reset_i(reset_i),
        .load_i(dispatch && rs0_empty), .op_i(dec_op),
        .src1_valid_i(opnd1[32]), .src1_tag_i(tag1), .src1_data_i(opnd1[31:0]),
        .src2_valid_i(opnd2[32]), .src2_tag_i(tag2), .src2_data_i(opnd2[31:0]),
        .dest_tag_i(alloc_tag),
        .cdb0_valid_i(rs0_fire), .cdb0_tag_i(rs0_tag), .cdb0_data_i(rs0_result),
        .cdb1_valid_i(rs1_fire), .cdb1_tag_i(rs1_tag), .cdb1_data_i(rs1_result),
        .empty_o(rs0_empty), .fire_o(rs0_fire), .fire_tag_o(rs0_tag), .result_o(rs0_result)
    );

    reservation_station rs1 (
        .clk(clk), .reset_i(reset_i),
        .load_i(dispatch && !rs0_empty), .op_i(dec_op),
        .src1_valid_i(opnd1[32]), .src1_tag_i(tag1), .src1_data_i(opnd1[31:0]),
        .src2_valid_i(opnd2[32]), .src2_tag_i(tag2), .src2_data_i(opnd2[31:0]),
        .dest_tag_i(alloc_tag),
        .cdb0_valid_i(rs0_fire), .cdb0_tag_i(rs0_tag), .cdb0_data_i(rs0_result),
        .cdb1_valid_i(rs1_fire), .cdb1_tag_i(rs1_tag), .cdb1_data_i(rs1_result),
        .empty_o(rs1_empty), .fire_o(rs1_fire), .fire_tag_o(rs1_tag), .result_o(rs1_result)
    );

    // both lanes may broadcast together, never for the same rob entry
    assert property (@(posedge clk) disable iff (reset_i)
        rs0_fire && rs1_fire |-> rs0_tag != rs1_tag);

endmodule : ooo

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD       = 8,
    parameter int RESET_CYCLES = 10
) (
    output logic clk_o,
    output logic reset_o
);

    // free running clock, starts low
    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD / 2) clk_o = ~clk_o;
        end
    end

    // synchronous reset, dropped right on a rising edge
    initial begin
        reset_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule : tb_clk_gen

// File: sim/tb_ooo.sv
`timescale 1ns/1ps

module tb_ooo;

    localparam int          NUM_INSTR        = 200;
    localparam int          CYCLES_PER_INSTR = 12;
    localparam int          RESET_CYCLES     = 10;
    localparam int          TIMEOUT_CYCLES   = NUM_INSTR * CYCLES_PER_INSTR + RESET_CYCLES;
    localparam int          DELAY_SLOTS      = 256;
    localparam logic [31:0] SEED             = 32'hccb8_452e;
    // addi x0, x0, 0
    localparam logic [31:0] NOP              = 32'h0000_0013;

    logic        clk;
    logic        reset_i;
    logic        instr_mem_resp_i  = 1'b0;
    logic [31:0] instr_mem_rdata_i = 32'd0;
    logic        instr_read_o;
    logic [31:0] instr_mem_address_o;
    logic        commit_valid_o;
    logic [4:0]  commit_rd_o;
    logic [31:0] commit_data_o;

    // program and in-order retirement trace from the model
    logic [31:0] prog     [NUM_INSTR];
    logic [4:0]  exp_rd   [NUM_INSTR];
    logic [31:0] exp_data [NUM_INSTR];
    // memory latency per fetch slot
    logic [2:0]  delay    [DELAY_SLOTS];

    // memory model state
    logic        pending   = 1'b0;
    logic [2:0]  wait_cnt  = 3'd0;
    logic [31:0] req_addr  = 32'd0;
    logic [31:0] next_addr = 32'd0;
    logic        reset_q   = 1'b0;
    int          retired   = 0;
    int          cycles    = 0;

    tb_clk_gen #(.PERIOD(8), .RESET_CYCLES(RESET_CYCLES)) clk_gen (
        .clk_o  (clk),
        .reset_o(reset_i)
    );

    ooo ooo_i (
        .clk                (clk),
        .reset_i            (reset_i),
        .instr_mem_resp_i   (instr_mem_resp_i),
        .instr_mem_rdata_i  (instr_mem_rdata_i),
        .instr_read_o       (instr_read_o),
        .instr_mem_address_o(instr_mem_address_o),
        .commit_valid_o     (commit_valid_o),
        .commit_rd_o        (commit_rd_o),
        .commit_data_o      (commit_data_o)
    );

    task automatic check_equal(
        input string       name,
        input logic [31:0] actual,
        input logic [31:0] expected
    );
        if (actual !== expected) begin
            $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            $display("TEST FAIL");
            $fatal(1);
        end
    endtask

    // half the picks land on x0..x3 to build dependency chains
    function automatic logic [4:0] pick_reg();
        if ($urandom_range(1, 0) == 1) begin
            return 5'($urandom_range(3, 0));
        end
        return 5'($urandom_range(31, 0));
    endfunction

    // rv32i integer semantics, alt is instruction bit 30
    function automatic logic [31:0] expected_result(
        input logic        is_reg,
        input logic [2:0]  funct3,
        input logic        alt,
        input logic [31:0] a,
        input logic [31:0] b
    );
        logic [31:0] r;
        case (funct3)
            3'b000:  r = (is_reg && alt) ? a - b : a + b;
            3'b001:  r = a << b[4:0];
            3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  r = (a < b) ? 32'd1 : 32'd0;
            3'b100:  r = a ^ b;
            3'b101: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'b110:  r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // random program plus the model run over it
    task automatic build_program();
        logic [31:0] regs [32];
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic        alt;
        logic [11:0] imm12;
        logic [19:0] imm20;
        logic [31:0] r;
        int          kind;
        for (int i = 0; i < 32; i++) begin
            regs[i] = 32'd0;
        end
        for (int i = 0; i < NUM_INSTR; i++) begin
            rd     = pick_reg();
            rs1    = pick_reg();
            rs2    = pick_reg();
            funct3 = 3'($urandom_range(7, 0));
            alt    = 1'b0;
            // sub and sra are the only funct7 variants
            if (funct3 == 3'b000 || funct3 == 3'b101) begin
                alt = 1'($urandom_range(1, 0));
            end
            kind = $urandom_range(9, 0);
            if (kind < 2) begin
                imm20   = 20'($urandom());
                prog[i] = {imm20, rd, 7'b0110111};
                r       = {imm20, 12'd0};
            end else if (kind < 6) begin
                prog[i] = {1'b0, alt, 5'd0, rs2, rs1, funct3, rd, 7'b0110011};
                r       = expected_result(1'b1, funct3, alt, regs[rs1], regs[rs2]);
            end else begin
                imm12 = 12'($urandom());
                // shift immediates carry funct7 and shamt
                if (funct3 == 3'b001 || funct3 == 3'b101) begin
                    imm12 = {1'b0, alt, 5'd0, imm12[4:0]};
                end
                prog[i] = {imm12, rs1, funct3, rd, 7'b0010011};
                r       = expected_result(1'b0, funct3, alt, regs[rs1],
                                          {{20{imm12[11]}}, imm12});
            end
            exp_rd[i]   = rd;
            exp_data[i] = r;
            // x0 retires on the trace but keeps zero
            if (rd != 5'd0) begin
                regs[rd] = r;
            end
        end
        for (int j = 0; j < DELAY_SLOTS; j++) begin
            delay[j] = 3'($urandom_range(4, 0));
        end
    endtask

    // past the program the memory returns padding
    function automatic logic [31:0] fetch_word(input logic [31:0] addr);
        if (addr[31:2] < NUM_INSTR) begin
            return prog[addr[31:2]];
        end
        return NOP;
    endfunction

    // instruction memory, answers after 0 to 4 cycles
    always @(posedge clk) begin
        instr_mem_resp_i <= 1'b0;
        if (reset_i) begin
            pending = 1'b0;
        end else if (instr_mem_resp_i) begin
            // word taken by ir at this edge
            pending = 1'b0;
        end else if (instr_read_o) begin
            if (!pending) begin
                check_equal("instr_mem_address_o", instr_mem_address_o, next_addr);
                pending   = 1'b1;
                req_addr  = instr_mem_address_o;
                next_addr = next_addr + 32'd4;
                wait_cnt  = delay[req_addr[9:2]];
            end else begin
                // address held while waiting
                check_equal("instr_mem_address_o", instr_mem_address_o, req_addr);
            end
            if (wait_cnt == 3'd0) begin
                instr_mem_resp_i  <= 1'b1;
                instr_mem_rdata_i <= fetch_word(req_addr);
            end else begin
                wait_cnt = wait_cnt - 3'd1;
            end
        end else if (pending) begin
            $display("instr_read_o dropped at address 0x%08h before the memory answered",
                     req_addr);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    // reset values, then the retirement trace in program order
    always @(posedge clk) begin
        if (reset_q) begin
            check_equal("instr_read_o", 32'(instr_read_o), 32'd0);
            check_equal("commit_valid_o", 32'(commit_valid_o), 32'd0);
        end
        reset_q = reset_i;
        if (!reset_i && commit_valid_o && retired < NUM_INSTR) begin
            check_equal($sformatf("commit_rd_o[%0d]", retired),
                        32'(commit_rd_o), 32'(exp_rd[retired]));
            check_equal($sformatf("commit_data_o[%0d]", retired),
                        commit_data_o, exp_data[retired]);
            retired = retired + 1;
        end
    end

    initial begin
        void'($urandom(SEED));
        build_program();
        // counted on the falling edge, away from the monitors
        while (retired < NUM_INSTR && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles = cycles + 1;
        end
        if (retired == NUM_INSTR) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("timeout after %0d cycles, only %0d of %0d instructions retired",
                     cycles, retired, NUM_INSTR);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

endmodule : tb_ooo

// File: ooo.f
+incdir+design
design/ooo_pkg.sv
design/alu.sv
design/ir.sv
design/rob.sv
design/regfile.sv
design/reservation_station.sv
design/ooo.sv
sim/tb_clk_gen.sv
sim/tb_ooo.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
TOP       ?= tb_ooo
FILELIST  ?= ooo.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TEST PASS" $(LOG) || (echo "no pass message in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
